/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

   localparam int ID_W    = 4;
   localparam int ADDR_W  = 32;
   localparam int DATA_W  = 32;
   localparam int STRB_W  = DATA_W / 8;
   localparam int LEN_W   = 8;
   localparam int SIZE_W  = 3;
   localparam int BURST_W = 2;
   localparam int RESP_W  = 2;

   localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
   localparam logic [RESP_W-1:0]  RESP_OKAY  = 2'b00;

   // single-beat write address
   typedef struct packed {
      logic [ADDR_W-1:0]  addr;
      logic [ID_W-1:0]    id;
      logic [LEN_W-1:0]   len;
      logic [SIZE_W-1:0]  size;
      logic [BURST_W-1:0] burst;
   } axi_aw_t;

   typedef struct packed {
      logic [ADDR_W-1:0]  addr;
      logic [ID_W-1:0]    id;
      logic [LEN_W-1:0]   len;
      logic [SIZE_W-1:0]  size;
      logic [BURST_W-1:0] burst;
   } axi_ar_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } axi_w_t;

   typedef struct packed {
      logic [RESP_W-1:0] resp;
      logic [ID_W-1:0]   id;
   } axi_b_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [RESP_W-1:0] resp;
      logic [ID_W-1:0]   id;
   } axi_r_t;

endpackage

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   // rv32i major opcodes
   localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
   localparam logic [6:0] OPCODE_STORE = 7'b0100011;

   localparam logic [2:0] F3_BYTE   = 3'b000;
   localparam logic [2:0] F3_HALF   = 3'b001;
   localparam logic [2:0] F3_WORD   = 3'b010;
   localparam logic [2:0] F3_BYTE_U = 3'b100;
   localparam logic [2:0] F3_HALF_U = 3'b101;

   // same encoding as the axi size field
   localparam logic [2:0] SIZE_BYTE = 3'd0;
   localparam logic [2:0] SIZE_HALF = 3'd1;
   localparam logic [2:0] SIZE_WORD = 3'd2;

   localparam int LANES = 4;

   // request from execute
   typedef struct packed {
      logic [31:0] inst;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] result;
      logic [31:0] next_pc;
      logic [31:0] csr_wdata;
   } lsu_req_t;

   typedef struct packed {
      logic       is_mem;
      logic       is_store;
      logic [2:0] size;
      logic       is_unsigned;   // lbu / lhu
      logic [1:0] offset;        // byte offset within the word
      logic       misaligned;
   } lsu_access_t;

   // to writeback
   typedef struct packed {
      logic [31:0] inst;
      logic [31:0] data;
      logic [31:0] next_pc;
      logic [31:0] csr_wdata;
   } lsu_wbu_t;

endpackage

`default_nettype wire

/* lsu_request_decoder.sv */
`default_nettype none

module lsu_request_decoder (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 accept,
   input  lsu_pkg::lsu_req_t    mem_req,
   output lsu_pkg::lsu_req_t    req,
   output lsu_pkg::lsu_access_t access
);

   function automatic lsu_pkg::lsu_access_t decode(input lsu_pkg::lsu_req_t r);
      lsu_pkg::lsu_access_t a;
      logic [6:0] opcode;
      logic [2:0] funct3;
      opcode = r.inst[6:0];
      funct3 = r.inst[14:12];
      a = '0;
      a.is_mem   = (opcode == lsu_pkg::OPCODE_LOAD) || (opcode == lsu_pkg::OPCODE_STORE);
      a.is_store = (opcode == lsu_pkg::OPCODE_STORE);
      a.offset   = r.addr[1:0];
      if (a.is_mem) begin
         case (funct3)
            lsu_pkg::F3_BYTE, lsu_pkg::F3_BYTE_U: a.size = lsu_pkg::SIZE_BYTE;
            lsu_pkg::F3_HALF, lsu_pkg::F3_HALF_U: a.size = lsu_pkg::SIZE_HALF;
            lsu_pkg::F3_WORD:                     a.size = lsu_pkg::SIZE_WORD;
            default:                              a.size = lsu_pkg::SIZE_BYTE; // unknown -> byte
         endcase
         // unsigned only means something for loads
         a.is_unsigned = !a.is_store &&
                         ((funct3 == lsu_pkg::F3_BYTE_U) || (funct3 == lsu_pkg::F3_HALF_U));
         if (a.size == lsu_pkg::SIZE_HALF) begin
            a.misaligned = r.addr[0];
         end else if (a.size == lsu_pkg::SIZE_WORD) begin
            a.misaligned = (r.addr[1:0] != 2'b00);
         end
      end
      return a;
   endfunction

   // held request
   always_ff @(posedge clock) begin
      if (accept) begin
         req <= mem_req;
      end
   end

   // decoded controls for the decode cycle
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         access <= '0;
      end else if (accept) begin
         access <= decode(mem_req);
      end
   end

endmodule

`default_nettype wire

/* lsu_byte_lane.sv */
`default_nettype none

module lsu_byte_lane #(
   parameter int LANE = 0
) (
   input  lsu_pkg::lsu_access_t        access,
   input  logic [axi_pkg::DATA_W-1:0]  wdata,
   input  logic [axi_pkg::DATA_W-1:0]  rdata,
   output logic                        strb,
   output logic [7:0]                  wbyte,
   output logic [7:0]                  rbyte,
   output logic                        keep
);

   localparam logic [2:0] LANE_IDX = 3'(LANE);

   logic [2:0] size_bytes;  // 1, 2 or 4
   logic [2:0] off;
   logic [1:0] wsel;        // store byte feeding this lane
   logic [1:0] rsel;        // read byte landing in this lane
   logic       in_window;
   logic       active;

   always_comb begin
      size_bytes = 3'd1 << access.size;
      off        = {1'b0, access.offset};
      wsel       = LANE_IDX[1:0] - access.offset;
      rsel       = access.offset + LANE_IDX[1:0];
      in_window  = (LANE_IDX >= off) && (LANE_IDX < off + size_bytes);
      active     = access.is_mem && !access.misaligned;

      strb  = active && access.is_store && in_window;
      wbyte = strb ? wdata[wsel*8 +: 8] : 8'h00;

      // load side shifts down by offset
      keep  = active && !access.is_store && (LANE_IDX < size_bytes);
      rbyte = keep ? rdata[rsel*8 +: 8] : 8'h00;
   end

endmodule

`default_nettype wire

/* lsu_lane_merge.sv */
`default_nettype none

module lsu_lane_merge (
   input  lsu_pkg::lsu_access_t       access,
   input  logic [lsu_pkg::LANES-1:0]  strb,
   input  logic [7:0]                 wbytes [lsu_pkg::LANES],
   input  logic [7:0]                 rbytes [lsu_pkg::LANES],
   input  logic [lsu_pkg::LANES-1:0]  keep,
   output axi_pkg::axi_w_t            w,
   output logic [axi_pkg::DATA_W-1:0] load_data
);

   logic fill;

   // write beat
   always_comb begin
      w      = '0;
      w.strb = strb;
      w.last = 1'b1;      // always single beat
      for (int i = 0; i < lsu_pkg::LANES; i++) begin
         w.data[i*8 +: 8] = wbytes[i];
      end
   end

   // extension bit from the highest kept byte
   always_comb begin
      fill = 1'b0;
      for (int i = 0; i < lsu_pkg::LANES; i++) begin
         if (keep[i]) begin
            fill = rbytes[i][7];
         end
      end
      if (access.is_unsigned) begin
         fill = 1'b0;
      end
   end

   always_comb begin
      for (int i = 0; i < lsu_pkg::LANES; i++) begin
         load_data[i*8 +: 8] = keep[i] ? rbytes[i] : {8{fill}};
      end
   end

endmodule

`default_nettype wire

/* lsu_axi_control.sv */
`default_nettype none

module lsu_axi_control (
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        mem_valid,
   output logic                        mem_ready,
   output logic                        accept,
   input  lsu_pkg::lsu_req_t           req,
   input  lsu_pkg::lsu_access_t        access,
   input  axi_pkg::axi_w_t             w_beat,
   input  logic [axi_pkg::DATA_W-1:0]  load_data,
   output logic                        aw_valid,
   input  logic                        aw_ready,
   output axi_pkg::axi_aw_t            aw,
   output logic                        w_valid,
   input  logic                        w_ready,
   output axi_pkg::axi_w_t             w,
   input  logic                        b_valid,
   output logic                        b_ready,
   input  axi_pkg::axi_b_t             b,
   output logic                        ar_valid,
   input  logic                        ar_ready,
   output axi_pkg::axi_ar_t            ar,
   input  logic                        r_valid,
   output logic                        r_ready,
   input  axi_pkg::axi_r_t             r,
   output logic                        wbu_valid,
   input  logic                        wbu_ready,
   output lsu_pkg::lsu_wbu_t           wbu_out
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_DECODE,
      ST_WADDR,
      ST_WDATA,
      ST_WRESP,
      ST_RADDR,
      ST_RDATA,
      ST_WBU
   } state_t;

   state_t                       state;
   state_t                       next_state;
   logic [axi_pkg::ID_W-1:0]     cur_id;
   logic [axi_pkg::DATA_W-1:0]   result_q;
   logic                         b_good;
   logic                         r_good;

   assign accept = mem_valid && (state == ST_IDLE);
   assign b_good = (b.resp == axi_pkg::RESP_OKAY) && (b.id == cur_id);
   assign r_good = (r.resp == axi_pkg::RESP_OKAY);   // rid is not checked

   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE:   if (mem_valid) next_state = ST_DECODE;
         ST_DECODE: begin
            if (!access.is_mem) begin
               next_state = ST_WBU;
            end else begin
               next_state = access.is_store ? ST_WADDR : ST_RADDR;
            end
         end
         ST_WADDR:  if (aw_ready) next_state = ST_WDATA;
         ST_WDATA:  if (w_ready) next_state = ST_WRESP;
         ST_WRESP:  if (b_valid) next_state = b_good ? ST_WBU : ST_IDLE;  // error drops item
         ST_RADDR:  if (ar_ready) next_state = ST_RDATA;
         ST_RDATA:  if (r_valid) next_state = r_good ? ST_WBU : ST_IDLE;
         ST_WBU:    if (wbu_ready) next_state = ST_IDLE;
         default:   next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state  <= ST_IDLE;
         cur_id <= '0;
      end else begin
         state <= next_state;
         if (accept) begin
            cur_id <= cur_id + 1'b1;  // new id per accepted request
         end
      end
   end

   // result for writeback
   always_ff @(posedge clock) begin
      if (state == ST_DECODE) begin
         result_q <= req.result;
      end else if (state == ST_RDATA && r_valid && r_good) begin
         result_q <= load_data;
      end
   end

   assign mem_ready = (state == ST_IDLE);
   assign aw_valid  = (state == ST_WADDR);
   assign w_valid   = (state == ST_WDATA);
   assign b_ready   = (state == ST_WRESP);
   assign ar_valid  = (state == ST_RADDR);
   assign r_ready   = (state == ST_RDATA);
   assign wbu_valid = (state == ST_WBU);

   always_comb begin
      aw       = '0;
      aw.addr  = req.addr;
      aw.id    = cur_id;
      aw.len   = '0;
      aw.size  = access.size;
      aw.burst = axi_pkg::BURST_INCR;
   end

   always_comb begin
      ar       = '0;
      ar.addr  = req.addr;
      ar.id    = cur_id;
      ar.len   = '0;
      ar.size  = access.size;
      ar.burst = axi_pkg::BURST_INCR;
   end

   assign w = w_beat;

   always_comb begin
      wbu_out           = '0;
      wbu_out.inst      = req.inst;
      wbu_out.data      = result_q;
      wbu_out.next_pc   = req.next_pc;
      wbu_out.csr_wdata = req.csr_wdata;
   end

endmodule

`default_nettype wire

/* lsu_top.sv */
`default_nettype none

module lsu_top (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 mem_valid,
   output logic                 mem_ready,
   input  lsu_pkg::lsu_req_t    mem_req,
   output logic                 wbu_valid,
   input  logic                 wbu_ready,
   output lsu_pkg::lsu_wbu_t    wbu_out,
   output logic                 aw_valid,
   input  logic                 aw_ready,
   output axi_pkg::axi_aw_t     aw,
   output logic                 w_valid,
   input  logic                 w_ready,
   output axi_pkg::axi_w_t      w,
   input  logic                 b_valid,
   output logic                 b_ready,
   input  axi_pkg::axi_b_t      b,
   output logic                 ar_valid,
   input  logic                 ar_ready,
   output axi_pkg::axi_ar_t     ar,
   input  logic                 r_valid,
   output logic                 r_ready,
   input  axi_pkg::axi_r_t      r
);

   logic                        accept;
   lsu_pkg::lsu_req_t           req;
   lsu_pkg::lsu_access_t        access;
   logic [lsu_pkg::LANES-1:0]   lane_strb;
   logic [lsu_pkg::LANES-1:0]   lane_keep;
   logic [7:0]                  lane_wbyte [lsu_pkg::LANES];
   logic [7:0]                  lane_rbyte [lsu_pkg::LANES];
   axi_pkg::axi_w_t             w_beat;
   logic [axi_pkg::DATA_W-1:0]  load_data;

   lsu_request_decoder u_decoder (
      .clock   (clock),
      .reset   (reset),
      .accept  (accept),
      .mem_req (mem_req),
      .req     (req),
      .access  (access)
   );

   // one steering slice per byte lane
   for (genvar g = 0; g < lsu_pkg::LANES; g++) begin : g_lane
      lsu_byte_lane #(.LANE(g)) u_lane (
         .access (access),
         .wdata  (req.wdata),
         .rdata  (r.data),
         .strb   (lane_strb[g]),
         .wbyte  (lane_wbyte[g]),
         .rbyte  (lane_rbyte[g]),
         .keep   (lane_keep[g])
      );
   end

   lsu_lane_merge u_merge (
      .access    (access),
      .strb      (lane_strb),
      .wbytes    (lane_wbyte),
      .rbytes    (lane_rbyte),
      .keep      (lane_keep),
      .w         (w_beat),
      .load_data (load_data)
   );

   lsu_axi_control u_control (
      .clock     (clock),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_ready (mem_ready),
      .accept    (accept),
      .req       (req),
      .access    (access),
      .w_beat    (w_beat),
      .load_data (load_data),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .aw        (aw),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .w         (w),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .b         (b),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .ar        (ar),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .r         (r),
      .wbu_valid (wbu_valid),
      .wbu_ready (wbu_ready),
      .wbu_out   (wbu_out)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
   output logic clock
);

   localparam int HALF_PERIOD = 2;  // period of 4

   initial begin
      clock = 1'b0;
      forever begin
         #HALF_PERIOD clock = ~clock;
      end
   end

endmodule

`default_nettype wire

/* tb_lsu.sv */
`default_nettype none

module tb_lsu;

   // stimulus and expected results for one request
   typedef struct packed {
      lsu_pkg::lsu_req_t req;
      logic [31:0]       rdata;      // slave read data
      logic [1:0]        resp;       // b or r response code
      logic [3:0]        exp_strb;
      logic [31:0]       exp_wdata;
      logic [31:0]       exp_data;   // writeback data
      logic              exp_err;
   } trace_item_t;

   logic                     clock;
   logic                     reset;
   logic                     mem_valid;
   logic                     mem_ready;
   lsu_pkg::lsu_req_t        mem_req;
   logic                     wbu_valid;
   logic                     wbu_ready;
   lsu_pkg::lsu_wbu_t        wbu_out;
   logic                     aw_valid;
   logic                     aw_ready;
   axi_pkg::axi_aw_t         aw;
   logic                     w_valid;
   logic                     w_ready;
   axi_pkg::axi_w_t          w;
   logic                     b_valid;
   logic                     b_ready;
   axi_pkg::axi_b_t          b;
   logic                     ar_valid;
   logic                     ar_ready;
   axi_pkg::axi_ar_t         ar;
   logic                     r_valid;
   logic                     r_ready;
   axi_pkg::axi_r_t          r;

   trace_item_t              items [$];
   int                       cycle_count = 0;
   int                       cycle_limit = 0;   // 0 until the trace is loaded
   logic [axi_pkg::ID_W-1:0] accepted = '0;     // accepted requests mod 16

   tb_clock_gen u_clock_gen (.clock(clock));

   lsu_top u_lsu_top (
      .clock     (clock),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_ready (mem_ready),
      .mem_req   (mem_req),
      .wbu_valid (wbu_valid),
      .wbu_ready (wbu_ready),
      .wbu_out   (wbu_out),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .aw        (aw),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .w         (w),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .b         (b),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .ar        (ar),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .r         (r)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_aw(input axi_pkg::axi_aw_t got, input axi_pkg::axi_aw_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: aw got 0x%h expected 0x%h", got, exp));
      end
   endtask

   task automatic check_ar(input axi_pkg::axi_ar_t got, input axi_pkg::axi_ar_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: ar got 0x%h expected 0x%h", got, exp));
      end
   endtask

   task automatic check_w(input axi_pkg::axi_w_t got, input axi_pkg::axi_w_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: w got 0x%h expected 0x%h", got, exp));
      end
   endtask

   task automatic check_wbu(input lsu_pkg::lsu_wbu_t got, input lsu_pkg::lsu_wbu_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: wbu_out got 0x%h expected 0x%h", got, exp));
      end
   endtask

   task automatic check_id(input string name, input logic [axi_pkg::ID_W-1:0] got,
                           input logic [axi_pkg::ID_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // inputs change and outputs are sampled on the falling edge
   task automatic step();
      @(negedge clock);
   endtask

   function automatic logic out_level(input string name);
      if (name == "w_valid") return w_valid;
      else if (name == "b_ready") return b_ready;
      else if (name == "r_ready") return r_ready;
      else if (name == "wbu_valid") return wbu_valid;
      else return mem_ready;
   endfunction

   // bounded by the global cycle counter
   task automatic wait_high(input string name);
      while (!out_level(name)) begin
         step();
      end
   endtask

   task automatic random_wait();
      int n;
      n = $urandom % 4;
      repeat (n) step();
   endtask

   function automatic logic [2:0] size_of(input logic [31:0] inst);
      case (inst[14:12])
         lsu_pkg::F3_HALF, lsu_pkg::F3_HALF_U: return lsu_pkg::SIZE_HALF;
         lsu_pkg::F3_WORD:                     return lsu_pkg::SIZE_WORD;
         default:                              return lsu_pkg::SIZE_BYTE;  // unknown too
      endcase
   endfunction

   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      trace_item_t it;
      logic [31:0] f [12];
      fd = $fopen("lsu_trace.txt", "r");
      if (fd == 0) begin
         abort_run("could not open lsu_trace.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() > 1 && line.getc(0) != 8'h23) begin   // skip blank and # lines
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            if (n != 12) begin
               abort_run($sformatf("malformed trace line: %s", line));
            end
            it.req.inst      = f[0];
            it.req.addr      = f[1];
            it.req.wdata     = f[2];
            it.req.result    = f[3];
            it.req.next_pc   = f[4];
            it.req.csr_wdata = f[5];
            it.rdata         = f[6];
            it.resp          = f[7][1:0];
            it.exp_strb      = f[8][3:0];
            it.exp_wdata     = f[9];
            it.exp_data      = f[10];
            it.exp_err       = f[11][0];
            items.push_back(it);
         end
      end
      $fclose(fd);
      if (items.size() == 0) begin
         abort_run("trace file holds no requests");
      end
   endtask

   // writeback under random back-pressure
   task automatic finish_writeback(input trace_item_t it);
      lsu_pkg::lsu_wbu_t exp;
      lsu_pkg::lsu_wbu_t held;
      int                n;
      exp.inst      = it.req.inst;
      exp.data      = it.exp_data;
      exp.next_pc   = it.req.next_pc;
      exp.csr_wdata = it.req.csr_wdata;
      wait_high("wbu_valid");
      check_wbu(wbu_out, exp);
      held = wbu_out;
      n = $urandom % 4;
      repeat (n) begin
         step();
         check_flag("wbu_valid", wbu_valid, 1'b1);
         check_wbu(wbu_out, held);
      end
      wbu_ready = 1'b1;
      step();
      wbu_ready = 1'b0;
      check_flag("mem_ready", mem_ready, 1'b1);
   endtask

   task automatic after_response(input trace_item_t it);
      if (it.exp_err) begin
         // item dropped and back to idle
         check_flag("wbu_valid", wbu_valid, 1'b0);
         check_flag("mem_ready", mem_ready, 1'b1);
      end else begin
         check_flag("wbu_valid", wbu_valid, 1'b1);
         finish_writeback(it);
      end
   endtask

   task automatic store_item(input trace_item_t it);
      axi_pkg::axi_aw_t exp_aw;
      axi_pkg::axi_w_t  exp_w;
      exp_aw       = '0;
      exp_aw.addr  = it.req.addr;
      exp_aw.id    = accepted;
      exp_aw.size  = size_of(it.req.inst);
      exp_aw.burst = axi_pkg::BURST_INCR;
      exp_w.data   = it.exp_wdata;
      exp_w.strb   = it.exp_strb;
      exp_w.last   = 1'b1;
      step();
      check_flag("aw_valid", aw_valid, 1'b1);
      check_id("aw.id", aw.id, accepted);
      check_aw(aw, exp_aw);
      random_wait();
      aw_ready = 1'b1;
      step();
      aw_ready = 1'b0;
      wait_high("w_valid");
      check_w(w, exp_w);
      random_wait();
      w_ready = 1'b1;
      step();
      w_ready = 1'b0;
      wait_high("b_ready");
      random_wait();
      b_valid = 1'b1;
      b.resp  = it.resp;
      b.id    = accepted;
      step();
      b_valid = 1'b0;
      b       = '0;
      after_response(it);
   endtask

   task automatic load_item(input trace_item_t it);
      axi_pkg::axi_ar_t exp_ar;
      exp_ar       = '0;
      exp_ar.addr  = it.req.addr;
      exp_ar.id    = accepted;
      exp_ar.size  = size_of(it.req.inst);
      exp_ar.burst = axi_pkg::BURST_INCR;
      step();
      check_flag("ar_valid", ar_valid, 1'b1);
      check_id("ar.id", ar.id, accepted);
      check_ar(ar, exp_ar);
      random_wait();
      ar_ready = 1'b1;
      step();
      ar_ready = 1'b0;
      wait_high("r_ready");
      random_wait();
      r_valid = 1'b1;
      r.data  = it.rdata;
      r.resp  = it.resp;
      r.id    = accepted;
      step();
      r_valid = 1'b0;
      r       = '0;
      after_response(it);
   endtask

   task automatic run_item(input trace_item_t it);
      logic [6:0] opcode;
      opcode = it.req.inst[6:0];
      check_flag("mem_ready", mem_ready, 1'b1);
      mem_valid = 1'b1;
      mem_req   = it.req;
      step();   // accepted on this edge
      mem_valid = 1'b0;
      accepted  = accepted + 4'd1;
      check_flag("mem_ready", mem_ready, 1'b0);   // decode cycle
      if (opcode == lsu_pkg::OPCODE_STORE) begin
         store_item(it);
      end else if (opcode == lsu_pkg::OPCODE_LOAD) begin
         load_item(it);
      end else begin
         step();
         check_flag("aw_valid", aw_valid, 1'b0);
         check_flag("ar_valid", ar_valid, 1'b0);
         check_flag("wbu_valid", wbu_valid, 1'b1);
         finish_writeback(it);
      end
   endtask

   always @(posedge clock) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count > cycle_limit) begin
         abort_run($sformatf("timeout after %0d cycles", cycle_count));
      end
   end

   // one channel at a time with idle counted as one
   always @(negedge clock) begin
      if (!reset && $countones({aw_valid, w_valid, b_ready, ar_valid, r_ready,
                                wbu_valid, mem_ready}) > 1) begin
         abort_run("more than one handshake signal high in the same cycle");
      end
   end

   initial begin
      void'($urandom(32'h56b8bd5c));
      reset     = 1'b1;
      mem_valid = 1'b0;
      mem_req   = '0;
      wbu_ready = 1'b0;
      aw_ready  = 1'b0;
      w_ready   = 1'b0;
      b_valid   = 1'b0;
      b         = '0;
      ar_ready  = 1'b0;
      r_valid   = 1'b0;
      r         = '0;
      load_trace();
      cycle_limit = items.size() * 40 + 100;
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      step();
      check_flag("mem_ready", mem_ready, 1'b1);
      check_flag("aw_valid", aw_valid, 1'b0);
      check_flag("w_valid", w_valid, 1'b0);
      check_flag("b_ready", b_ready, 1'b0);
      check_flag("ar_valid", ar_valid, 1'b0);
      check_flag("r_ready", r_ready, 1'b0);
      check_flag("wbu_valid", wbu_valid, 1'b0);
      foreach (items[i]) begin
         run_item(items[i]);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* lsu_trace.txt */
# inst addr wdata result next_pc csr_wdata rdata resp, then expected strb wdata wbu_data error
# all fields hex, one request per line
00a52023 80001000 deadbeef 00000011 00000104 0000abcd 00000000 0 f deadbeef 00000011 0
00052283 80001000 00000000 00000022 00000108 00000000 cafef00d 0 0 00000000 cafef00d 0
00a50023 80001003 000000a5 00000033 0000010c 00000000 00000000 0 8 a5000000 00000033 0
00a50023 80001001 12345678 00000034 00000110 00000000 00000000 0 2 00007800 00000034 0
00a51023 80001002 1234beef 00000035 00000114 00000000 00000000 0 c beef0000 00000035 0
00a51023 80001000 ffff1357 00000036 00000118 00000000 00000000 0 3 00001357 00000036 0
00a51023 80001001 0000abcd 00000037 0000011c 00000000 00000000 0 0 00000000 00000037 0
00a52023 80001002 11223344 00000038 00000120 00000000 00000000 0 0 00000000 00000038 0
00050283 80002002 00000000 00000039 00000124 00000000 11f23344 0 0 00000000 fffffff2 0
00054283 80002002 00000000 0000003a 00000128 00000000 11f23344 0 0 00000000 000000f2 0
00051283 80002002 00000000 0000003b 0000012c 00000000 8001aaaa 0 0 00000000 ffff8001 0
00055283 80002000 00000000 0000003c 00000130 00000000 12349876 0 0 00000000 00009876 0
00051283 80002000 00000000 0000003d 00000134 00000000 00007fff 0 0 00000000 00007fff 0
00051283 80002003 00000000 0000003e 00000138 00000000 ffffffff 0 0 00000000 00000000 0
00052283 80002001 00000000 0000003f 0000013c 00000000 12345678 0 0 00000000 00000000 0
00050283 80002003 00000000 00000040 00000140 00000000 7f000000 0 0 00000000 0000007f 0
00150513 00000000 00000000 00000042 00000144 00000000 00000000 0 0 00000000 00000042 0
123450b7 00000000 00000000 12345000 00000148 00000000 00000000 0 0 00000000 12345000 0
34011073 00000000 00000000 00001800 0000014c 80000004 00000000 0 0 00000000 00001800 0
00a52023 80004000 55aa55aa 00000043 00000150 00000000 00000000 2 f 55aa55aa 00000000 1
00052283 80004000 00000000 00000044 00000154 00000000 12345678 3 0 00000000 00000000 1
00053283 80003001 00000000 00000045 00000158 00000000 0000c300 0 0 00000000 ffffffc3 0
00056283 80003002 00000000 00000046 0000015c 00000000 00800000 0 0 00000000 ffffff80 0
00a57023 80003002 000000aa 00000047 00000160 00000000 00000000 0 4 00aa0000 00000047 0
00054283 80003000 00000000 00000048 00000164 00000000 000000ff 0 0 00000000 000000ff 0
00208463 00000000 00000000 00000000 00000200 00000000 00000000 0 0 00000000 00000000 0
00a52023 80005000 a1b2c3d4 00000049 00000204 00000000 00000000 1 f a1b2c3d4 00000000 1

/* project.f */
axi_pkg.sv
lsu_pkg.sv
lsu_request_decoder.sv
lsu_byte_lane.sv
lsu_lane_merge.sv
lsu_axi_control.sv
lsu_top.sv
tb_clock_gen.sv
tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_lsu -f project.f --Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "^all tests passed$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
